// ==== hw/mac_macros.svh ====
`ifndef MAC_MACROS_SVH
`define MAC_MACROS_SVH

// Producer tag, one per ROB slot
`define MAC_TAG_W 4

// Operand and result word
`define MAC_DATA_W 16

// Unresolved older branches
`define MAC_BR_W 3

`endif

// ==== hw/mac_pkg.sv ====
`default_nettype none
`include "mac_macros.svh"

package mac_pkg;
	typedef struct packed {
		logic rdy; // data valid, else waiting on tag
		logic [`MAC_TAG_W-1:0] tag;
		logic [`MAC_DATA_W-1:0] data;
	} operand_t;

	typedef struct packed {
		logic valid;
		logic [`MAC_TAG_W-1:0] tag;
		logic [`MAC_DATA_W-1:0] data;
	} cdb_t;

	typedef struct packed {
		logic [`MAC_TAG_W-1:0] dst;
		operand_t a;
		operand_t b;
		operand_t c;
		logic [`MAC_BR_W-1:0] br;
	} issue_t;

	typedef struct packed {
		logic [`MAC_TAG_W-1:0] tag;
		logic [`MAC_DATA_W-1:0] value;
	} result_t;

	// Multiplier operands with the tag riding along
	typedef struct packed {
		logic [`MAC_TAG_W-1:0] dst;
		logic [`MAC_DATA_W-1:0] a;
		logic [`MAC_DATA_W-1:0] b;
	} prod_op_t;

	function automatic logic tag_match(cdb_t bus, logic [`MAC_TAG_W-1:0] tag);
		return bus.valid && (bus.tag == tag);
	endfunction
endpackage

`default_nettype wire

// ==== hw/addend_station.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mac_macros.svh"

module addend_station (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input wire mac_pkg::issue_t issue,
	input wire logic issue_ready,
	input wire mac_pkg::cdb_t cdb,
	input wire logic br_commit,
	input wire logic br_fail,
	input wire logic take,
	output logic busy,
	output logic go,
	output logic [`MAC_DATA_W-1:0] addend
);
	import mac_pkg::*;

	logic held;
	operand_t c_q;
	logic [`MAC_BR_W-1:0] br_q;

	operand_t c_upd;
	operand_t c_new;
	logic [`MAC_BR_W-1:0] br_upd;
	logic accept;
	logic flush_held;
	logic flush_new;

	assign accept = issue_valid && issue_ready;

	// Only an unconfirmed entry is killed by a misprediction
	assign flush_held = br_fail && held && (br_q != '0);
	assign flush_new = br_fail && (issue.br != '0);

	always_comb begin
		c_upd = c_q;
		if (!c_q.rdy && tag_match(cdb, c_q.tag)) begin
			c_upd.rdy = 1'b1;
			c_upd.data = cdb.data;
		end

		// Producer may broadcast in the same cycle we issue
		c_new = issue.c;
		if (!issue.c.rdy && tag_match(cdb, issue.c.tag)) begin
			c_new.rdy = 1'b1;
			c_new.data = cdb.data;
		end
	end

	assign br_upd = (br_q != '0 && br_commit) ? br_q - 1'b1 : br_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else if (accept) begin
			held <= !flush_new; // reload, possibly after take
		end else if (take || flush_held) begin
			held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			c_q <= c_new;
			br_q <= issue.br;
		end else begin
			c_q <= c_upd;
			br_q <= br_upd;
		end
	end

	assign busy = held;
	assign go = held && (br_q == '0) && c_q.rdy;
	assign addend = c_q.data;
endmodule

`default_nettype wire

// ==== hw/product_station.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mac_macros.svh"

module product_station (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input wire mac_pkg::issue_t issue,
	input wire logic issue_ready,
	input wire mac_pkg::cdb_t cdb,
	input wire logic br_commit,
	input wire logic br_fail,
	input wire logic take,
	output logic busy,
	output logic go,
	output mac_pkg::prod_op_t prod_op
);
	import mac_pkg::*;

	logic held;
	logic [`MAC_TAG_W-1:0] dst_q;
	operand_t a_q;
	operand_t b_q;
	logic [`MAC_BR_W-1:0] br_q;

	operand_t a_upd;
	operand_t b_upd;
	operand_t a_new;
	operand_t b_new;
	logic [`MAC_BR_W-1:0] br_upd;
	logic accept;
	logic flush_held;
	logic flush_new;

	// Pick up a waiting operand off the CDB
	function automatic operand_t snoop(operand_t op, cdb_t bus);
		operand_t r;
		r = op;
		if (!op.rdy && tag_match(bus, op.tag)) begin
			r.rdy = 1'b1;
			r.data = bus.data;
		end
		return r;
	endfunction

	assign accept = issue_valid && issue_ready;
	assign flush_held = br_fail && held && (br_q != '0);
	assign flush_new = br_fail && (issue.br != '0);

	// a and b resolve independently
	assign a_upd = snoop(a_q, cdb);
	assign b_upd = snoop(b_q, cdb);
	assign a_new = snoop(issue.a, cdb);
	assign b_new = snoop(issue.b, cdb);

	assign br_upd = (br_q != '0 && br_commit) ? br_q - 1'b1 : br_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else if (accept) begin
			held <= !flush_new;
		end else if (take || flush_held) begin
			held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dst_q <= issue.dst;
			a_q <= a_new;
			b_q <= b_new;
			br_q <= issue.br;
		end else begin
			a_q <= a_upd;
			b_q <= b_upd;
			br_q <= br_upd;
		end
	end

	assign busy = held;
	assign go = held && (br_q == '0) && a_q.rdy && b_q.rdy;

	always_comb begin
		prod_op.dst = dst_q;
		prod_op.a = a_q.data;
		prod_op.b = b_q.data;
	end
endmodule

`default_nettype wire

// ==== hw/mac_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mac_macros.svh"

module mac_unit (
	input wire logic clk,
	input wire logic rst,
	input wire logic add_busy,
	input wire logic add_go,
	input wire logic [`MAC_DATA_W-1:0] addend,
	input wire logic prod_busy,
	input wire logic prod_go,
	input wire mac_pkg::prod_op_t prod_op,
	output logic take,
	output logic issue_ready,
	output logic result_valid,
	output mac_pkg::result_t result,
	input wire logic result_ready
);
	import mac_pkg::*;

	// Stage one: product and addend
	logic s1_valid;
	logic [`MAC_TAG_W-1:0] s1_tag;
	logic [`MAC_DATA_W-1:0] s1_prod;
	logic [`MAC_DATA_W-1:0] s1_addend;

	// Stage two: finished sum
	logic s2_valid;
	result_t s2_res;

	logic [`MAC_DATA_W-1:0] prod_lo;
	logic s1_free;
	logic s2_free;

	assign prod_lo = prod_op.a * prod_op.b; // low half only

	assign s2_free = !s2_valid || result_ready;
	assign s1_free = !s1_valid || s2_free;

	// Both halves of the instruction must be ready together
	assign take = add_go && prod_go && s1_free;

	// A station slot opens when its entry leaves or is empty
	assign issue_ready = take || (!add_busy && !prod_busy);

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else if (s1_free) begin
			s1_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			s1_tag <= prod_op.dst;
			s1_prod <= prod_lo;
			s1_addend <= addend;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s2_valid <= 1'b0;
		end else if (s2_free) begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s2_free && s1_valid) begin
			s2_res.tag <= s1_tag;
			s2_res.value <= s1_prod + s1_addend; // wraps mod 2^16
		end
	end

	assign result_valid = s2_valid;
	assign result = s2_res;
endmodule

`default_nettype wire

// ==== hw/mac_slice.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mac_macros.svh"

module mac_slice (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input wire mac_pkg::issue_t issue,
	output logic issue_ready,
	input wire mac_pkg::cdb_t cdb,
	input wire logic br_commit,
	input wire logic br_fail,
	output logic result_valid,
	output mac_pkg::result_t result,
	input wire logic result_ready
);
	import mac_pkg::*;

	logic add_busy;
	logic add_go;
	logic [`MAC_DATA_W-1:0] addend;
	logic prod_busy;
	logic prod_go;
	prod_op_t prod_op;
	logic take;

	// Operand c
	addend_station u_addend (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.cdb(cdb),
		.br_commit(br_commit),
		.br_fail(br_fail),
		.take(take),
		.busy(add_busy),
		.go(add_go),
		.addend(addend)
	);

	// Operands a and b
	product_station u_product (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.cdb(cdb),
		.br_commit(br_commit),
		.br_fail(br_fail),
		.take(take),
		.busy(prod_busy),
		.go(prod_go),
		.prod_op(prod_op)
	);

	mac_unit u_mac (
		.clk(clk),
		.rst(rst),
		.add_busy(add_busy),
		.add_go(add_go),
		.addend(addend),
		.prod_busy(prod_busy),
		.prod_go(prod_go),
		.prod_op(prod_op),
		.take(take),
		.issue_ready(issue_ready),
		.result_valid(result_valid),
		.result(result),
		.result_ready(result_ready)
	);
endmodule

`default_nettype wire

// ==== bench/mac_slice_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_slice_assertions (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_ready,
	input wire logic result_valid,
	input wire mac_pkg::result_t result,
	input wire logic result_ready
);
	// Synchronous reset empties both pipeline stages
	a_valid_after_reset: assert property (@(posedge clk) rst |=> !result_valid)
		else $error("result_valid high in the cycle after reset");

	// Held result under back-pressure
	a_result_stable: assert property (@(posedge clk) disable iff (rst)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else $error("result changed or dropped while result_ready was low");

	a_ready_after_reset: assert property (@(posedge clk) rst |=> issue_ready)
		else $error("issue_ready low in the cycle after reset"); // stations empty
endmodule

bind mac_slice mac_slice_assertions u_assertions (
	.clk(clk),
	.rst(rst),
	.issue_ready(issue_ready),
	.result_valid(result_valid),
	.result(result),
	.result_ready(result_ready)
);

`default_nettype wire

// ==== bench/mac_slice_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mac_macros.svh"

module mac_slice_tb;
	import mac_pkg::*;

	localparam int N_INSTR = 120;
	localparam int TIMEOUT = 40 * N_INSTR + 200;

	logic clk;
	logic rst;
	logic issue_valid;
	issue_t issue;
	logic issue_ready;
	cdb_t cdb;
	logic br_commit;
	logic br_fail;
	logic result_valid;
	result_t result;
	logic result_ready;

	logic [15:0] lfsr;
	int cycles = 0;
	int errors;
	int accepted;
	int results;
	int flushed;
	int stalls;
	int first_accept;
	result_t exp_q[$];

	// Instruction offered on the issue port
	logic offer;
	logic [2:0] nxt_wait;
	logic [`MAC_TAG_W-1:0] nxt_tag [3];
	logic [`MAC_DATA_W-1:0] nxt_val [3];
	logic [`MAC_BR_W-1:0] nxt_br;
	logic [`MAC_TAG_W-1:0] src_tag;
	logic [`MAC_TAG_W-1:0] dst_tag;

	// Station entry while operands or branches are still outstanding
	logic [2:0] ent_wait;
	logic [`MAC_TAG_W-1:0] ent_tag [3];
	logic [`MAC_DATA_W-1:0] ent_val [3];
	logic [`MAC_BR_W-1:0] ent_br;

	mac_slice DUT (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.cdb(cdb),
		.br_commit(br_commit),
		.br_fail(br_fail),
		.result_valid(result_valid),
		.result(result),
		.result_ready(result_ready)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: only %0d of %0d instructions accepted", accepted, N_INSTR);
			$display("errors=%0d results=%0d flushed=%0d", errors, results, flushed);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Galois LFSR, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic operand_t make_operand(logic waiting, logic [`MAC_TAG_W-1:0] tag,
			logic [`MAC_DATA_W-1:0] val);
		operand_t op;
		op.rdy = !waiting;
		op.tag = tag;
		op.data = waiting ? ~val : val; // junk until the producer broadcasts
		return op;
	endfunction

	task automatic new_instr();
		for (int i = 0; i < 3; i++) begin
			nxt_val[i] = rand_bits(16);
			nxt_wait[i] = (accepted != 0) && (rand_bits(2) == 16'd0);
			nxt_tag[i] = src_tag;
			if (nxt_wait[i]) begin
				src_tag++;
			end
		end
		nxt_br = '0;
		if (accepted != 0 && rand_bits(2) == 16'd0) begin
			nxt_br = 3'(rand_bits(2)) + 3'd1;
		end
		issue.dst = dst_tag;
		issue.a = make_operand(nxt_wait[0], nxt_tag[0], nxt_val[0]);
		issue.b = make_operand(nxt_wait[1], nxt_tag[1], nxt_val[1]);
		issue.c = make_operand(nxt_wait[2], nxt_tag[2], nxt_val[2]);
		issue.br = nxt_br;
		dst_tag++;
		offer = 1'b1;
	endtask

	task automatic drive_cycle();
		logic [15:0] r;
		int k;
		int s;
		cdb = '0;
		br_commit = 1'b0;
		br_fail = 1'b0;
		if (ent_br != '0) begin
			r = rand_bits(6);
			if (r == 16'd0) begin
				br_fail = 1'b1;
			end else if (r < 16'd16) begin
				br_commit = 1'b1;
			end
		end
		if (ent_wait != '0 && rand_bits(2) == 16'd0) begin
			k = int'(rand_bits(2));
			for (int i = 0; i < 3; i++) begin
				s = (k + i) % 3;
				if (ent_wait[s] && !cdb.valid) begin
					cdb.valid = 1'b1;
					cdb.tag = ent_tag[s];
					cdb.data = ent_val[s];
				end
			end
		end
		if (cycles < 12) begin
			result_ready = 1'b1; // first result measures latency
		end else if (accepted < N_INSTR / 2) begin
			result_ready = (rand_bits(3) != 16'd0);
		end else begin
			result_ready = (rand_bits(1) != 16'd0);
		end
		if (!offer && accepted < N_INSTR && (accepted == 0 || rand_bits(2) != 16'd0)) begin
			new_instr();
		end
		issue_valid = offer;
	endtask

	// Handshakes that complete at the coming rising edge
	task automatic observe_edge();
		result_t head;
		result_t exp;
		logic busy_ent;
		busy_ent = (ent_wait != '0) || (ent_br != '0);
		if (issue_valid && !issue_ready && !busy_ent) begin
			stalls++;
		end
		if (result_valid && result_ready) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Result with tag %h appeared with no instruction outstanding", result.tag);
			end
			if (exp_q.size() != 0) begin
				assert (!(exp_q.size() == 1 && busy_ent)) else begin
					errors++;
					$display("Result came out before its operands or branches were resolved");
				end
				if (results == 0) begin
					assert (cycles - first_accept == 3) else begin
						errors++;
						$display("First result took %0d cycles instead of 3", cycles - first_accept);
					end
				end
				head = exp_q.pop_front();
				assert (result.tag == head.tag) else begin
					errors++;
					$display("[FAIL] result.tag = %h, expected %h", result.tag, head.tag);
				end
				assert (result.value == head.value) else begin
					errors++;
					$display("[FAIL] result.value = %h, expected %h", result.value, head.value);
				end
			end
			results++;
		end
		if (br_fail && ent_br != '0) begin
			head = exp_q.pop_back(); // flushed entry is always the youngest
			ent_wait = '0;
			ent_br = '0;
			flushed++;
		end else if (br_commit && ent_br != '0) begin
			ent_br--;
		end
		for (int i = 0; i < 3; i++) begin
			if (cdb.valid && ent_wait[i] && ent_tag[i] == cdb.tag) begin
				ent_wait[i] = 1'b0;
			end
		end
		if (issue_valid && issue_ready) begin
			assert (ent_wait == '0 && ent_br == '0) else begin
				errors++;
				$display("Issue accepted while the station entry was still waiting");
			end
			ent_wait = nxt_wait;
			ent_tag = nxt_tag;
			ent_val = nxt_val;
			ent_br = nxt_br;
			exp.tag = issue.dst;
			exp.value = nxt_val[0] * nxt_val[1] + nxt_val[2];
			exp_q.push_back(exp);
			if (accepted == 0) begin
				first_accept = cycles;
			end
			accepted++;
			offer = 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		cdb = '0;
		br_commit = 1'b0;
		br_fail = 1'b0;
		result_ready = 1'b0;
		lfsr = 16'd19;
		errors = 0;
		accepted = 0;
		results = 0;
		flushed = 0;
		stalls = 0;
		first_accept = 0;
		offer = 1'b0;
		src_tag = '0;
		dst_tag = '0;
		ent_wait = '0;
		ent_br = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (accepted < N_INSTR || exp_q.size() != 0) begin
			drive_cycle();
			#2;
			observe_edge();
			@(negedge clk);
		end
		// Quiet tail, nothing more may come out
		repeat (10) begin
			drive_cycle();
			#2;
			observe_edge();
			@(negedge clk);
		end
		assert (stalls > 0) else begin
			errors++;
			$display("issue_ready never fell while the pipeline was full");
		end
		$display("errors=%0d results=%0d flushed=%0d accepted=%0d stalls=%0d",
			errors, results, flushed, accepted, stalls);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end
endmodule

`default_nettype wire

// ==== mac_slice.f ====
+incdir+hw
hw/mac_pkg.sv
hw/addend_station.sv
hw/product_station.sv
hw/mac_unit.sv
hw/mac_slice.sv
bench/mac_slice_assertions.sv
bench/mac_slice_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module mac_slice_tb \
		-f mac_slice.f -o mac_slice_sim

run: compile
	@out="$$(./obj_dir/mac_slice_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
